/* design/alu_multiply.sv */
// pipelined signed multiplier, result_o = a_i * b_i, both signed
// four register stages, fixed, new operand pair accepted every clock
// operands are split into a signed upper part and an unsigned lower part,
// the four partial products map onto small hardware multipliers
// DATA_W must be 4 or more

`timescale 1ns/100ps
`default_nettype none

module alu_multiply #(
	parameter int DATA_W = 33
) (
	input  wire logic                clk_i,
	input  wire logic                rst_i,
	input  wire logic [DATA_W-1:0]   a_i,
	input  wire logic [DATA_W-1:0]   b_i,
	output logic      [2*DATA_W-1:0] result_o
);

	localparam int HI_W  = DATA_W / 2;		// signed upper part
	localparam int LO_W  = DATA_W - HI_W;	// unsigned lower part, >= HI_W
	localparam int MID_W = DATA_W + 1;		// cross terms, one bit of margin
	localparam int DBL_W = 2 * DATA_W;

	logic signed [DATA_W-1:0] a_r, b_r;
	logic signed [HI_W-1:0]   a_hi, b_hi;
	logic signed [LO_W:0]     a_lo_ze, b_lo_ze;	// extra zero msb keeps these positive
	logic signed [2*HI_W-1:0] mult_hi_hi;
	logic signed [MID_W-1:0]  mult_hi_lo, mult_lo_hi;
	logic        [2*LO_W-1:0] mult_lo_lo;		// raw bits, always >= 0
	logic signed [DBL_W-1:0]  inner_sum, outer_cat;

	// stage 1, operand registers
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			a_r <= '0;
			b_r <= '0;
		end else begin
			a_r <= a_i;
			b_r <= b_i;
		end
	end

	// split operands
	assign a_hi    = a_r[DATA_W-1:LO_W];
	assign b_hi    = b_r[DATA_W-1:LO_W];
	assign a_lo_ze = {1'b0, a_r[LO_W-1:0]};
	assign b_lo_ze = {1'b0, b_r[LO_W-1:0]};

	// stage 2, partial products
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			mult_hi_hi <= '0;
			mult_hi_lo <= '0;
			mult_lo_hi <= '0;
			mult_lo_lo <= '0;
		end else begin
			mult_hi_hi <= a_hi * b_hi;
			mult_hi_lo <= a_hi * b_lo_ze;
			mult_lo_hi <= a_lo_ze * b_hi;
			mult_lo_lo <= a_lo_ze * b_lo_ze;	// unsigned lo x lo
		end
	end

	// stage 3
	// cross terms are sign extended to DBL_W before the add, then shifted up
	// outer terms do not overlap so a concat does the add for free
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			inner_sum <= '0;
			outer_cat <= '0;
		end else begin
			inner_sum <= (DBL_W'(mult_hi_lo) + DBL_W'(mult_lo_hi)) <<< LO_W;
			outer_cat <= {mult_hi_hi, mult_lo_lo};
		end
	end

	// stage 4, final add, wraps mod 2^DBL_W which holds any signed product
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			result_o <= '0;
		end else begin
			result_o <= outer_cat + inner_sum;
		end
	end

endmodule

`default_nettype wire

/* design/mul_latency_timer.sv */
// latency timer, load on edge N gives done after edge N+LAT
// done is one clock wide, a reload restarts the count
// LAT must be 1 or more

`timescale 1ns/100ps
`default_nettype none

module mul_latency_timer #(
	parameter int LAT = 4
) (
	input  wire logic clk_i,
	input  wire logic rst_i,
	input  wire logic tmr_load_i,
	output logic      tmr_done_o
);

	localparam int CNT_W = $clog2(LAT + 1);

	logic [CNT_W-1:0] cnt;	// 0 = idle

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			cnt        <= '0;
			tmr_done_o <= 1'b0;
		end else if (tmr_load_i) begin
			cnt        <= CNT_W'(LAT);
			tmr_done_o <= 1'b0;
		end else begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			tmr_done_o <= (cnt == CNT_W'(1));	// last step, pipe flushed
		end
	end

endmodule

`default_nettype wire

/* design/mul_pkg.sv */
// shared types and constants for the multiply unit
// register addresses are word addresses, accesses are full 32-bit words
// MUL_LAT must match the register stages of alu_multiply

`default_nettype none

package mul_pkg;

	// opcode, lives in ctrl bits 1:0
	typedef enum logic [1:0] {
		MUL_LO  = 2'd0,	// low half, sign irrelevant
		MULH_SS = 2'd1,	// high half, signed x signed
		MULH_UU = 2'd2,	// high half, unsigned x unsigned
		MULH_SU = 2'd3	// high half, signed a x unsigned b
	} mul_op_e;

	// sequencer states
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_RUN  = 2'd1,	// waiting on the pipe
		ST_DONE = 2'd2	// capture cycle
	} mul_state_e;

	// register map
	localparam logic [1:0] REG_OP_A   = 2'd0;	// r/w
	localparam logic [1:0] REG_OP_B   = 2'd1;	// r/w
	localparam logic [1:0] REG_CTRL   = 2'd2;	// wr starts op, rd is status
	localparam logic [1:0] REG_RESULT = 2'd3;	// read only

	// operand in to product out, in clocks
	localparam int MUL_LAT = 4;

endpackage

`default_nettype wire

/* design/mul_regs.sv */
// wishbone classic slave, full-word accesses only, no err/rty/bursts
// ack is registered, one clock wide, never back to back
// any write and any result read stall while busy, status reads never stall
// operands are widened one bit here so one signed multiplier covers all opcodes

`timescale 1ns/100ps
`default_nettype none

module mul_regs
	import mul_pkg::*;
#(
	parameter int OP_W = 32
) (
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	input  wire logic              wb_cyc_i,
	input  wire logic              wb_stb_i,
	input  wire logic              wb_we_i,
	input  wire logic [1:0]        wb_adr_i,
	input  wire logic [OP_W-1:0]   wb_dat_i,
	output logic      [OP_W-1:0]   wb_dat_o,
	output logic                   wb_ack_o,
	input  wire logic              busy_i,
	input  wire logic              capture_i,
	input  wire logic [2*OP_W+1:0] product_i,	// only the low 2*OP_W bits matter
	output logic                   start_o,
	output logic      [OP_W:0]     op_a_o,
	output logic      [OP_W:0]     op_b_o
);

	logic [OP_W-1:0] op_a, op_b, result;
	mul_op_e         opcode;
	logic            req, must_wait, stall, ack_d;
	logic            sign_a, sign_b;

	assign req       = wb_cyc_i & wb_stb_i;
	assign must_wait = wb_we_i | (wb_adr_i == REG_RESULT);
	assign stall     = must_wait & busy_i;
	assign ack_d     = req & ~wb_ack_o & ~stall;	// no ack right after an ack

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			wb_ack_o <= 1'b0;
			start_o  <= 1'b0;
			op_a     <= '0;
			op_b     <= '0;
			opcode   <= MUL_LO;
			result   <= '0;
		end else begin
			wb_ack_o <= ack_d;
			start_o  <= ack_d & wb_we_i & (wb_adr_i == REG_CTRL);
			if (ack_d && wb_we_i) begin
				case (wb_adr_i)
					REG_OP_A: op_a   <= wb_dat_i;
					REG_OP_B: op_b   <= wb_dat_i;
					REG_CTRL: opcode <= mul_op_e'(wb_dat_i[1:0]);
					default:  ;	// result is read only
				endcase
			end
			// grab the half the opcode asks for
			if (capture_i) begin
				if (opcode == MUL_LO)
					result <= product_i[OP_W-1:0];
				else
					result <= product_i[2*OP_W-1:OP_W];
			end
		end
	end

	// widening, a signed for SS and SU, b signed for SS only
	assign sign_a = (opcode == MULH_SS) || (opcode == MULH_SU);
	assign sign_b = (opcode == MULH_SS);
	assign op_a_o = {sign_a & op_a[OP_W-1], op_a};
	assign op_b_o = {sign_b & op_b[OP_W-1], op_b};

	// read mux, sampled by the master while ack is high
	always_comb begin
		case (wb_adr_i)
			REG_OP_A: wb_dat_o = op_a;
			REG_OP_B: wb_dat_o = op_b;
			REG_CTRL: wb_dat_o = {{(OP_W-3){1'b0}}, opcode, busy_i};	// status
			default:  wb_dat_o = result;
		endcase
	end

endmodule

`default_nettype wire

/* design/mul_seq_fsm.sv */
// sequencer for one multiply at a time
// start is ignored unless idle, the register block stalls writes anyway
// capture is a single clock pulse, busy drops on the same edge

`timescale 1ns/100ps
`default_nettype none

module mul_seq_fsm
	import mul_pkg::*;
(
	input  wire logic clk_i,
	input  wire logic rst_i,
	input  wire logic start_i,
	input  wire logic tmr_done_i,
	output logic      tmr_load_o,
	output logic      busy_o,
	output logic      capture_o
);

	mul_state_e state, state_nxt;

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (start_i)
					state_nxt = ST_RUN;
			end
			ST_RUN: begin
				if (tmr_done_i)	// pipe output now belongs to this op
					state_nxt = ST_DONE;
			end
			ST_DONE: state_nxt = ST_IDLE;	// one capture clock
			default: state_nxt = ST_IDLE;
		endcase
	end

	// load lands on the same edge that enters ST_RUN
	assign tmr_load_o = (state == ST_IDLE) & start_i;
	assign busy_o     = (state != ST_IDLE);
	assign capture_o  = (state == ST_DONE);

endmodule

`default_nettype wire

/* design/mul_unit_top.sv */
// memory-mapped multiply unit, wishbone classic slave
// write A, write B, write opcode to ctrl, then read result
// result read and any write stall with ack low for LAT+2 clocks after a start
// only one operation in flight at a time

`timescale 1ns/100ps
`default_nettype none

module mul_unit_top
	import mul_pkg::*;
#(
	parameter int OP_W = 32
) (
	input  wire logic            clk_i,
	input  wire logic            rst_i,
	input  wire logic            wb_cyc_i,
	input  wire logic            wb_stb_i,
	input  wire logic            wb_we_i,
	input  wire logic [1:0]      wb_adr_i,
	input  wire logic [OP_W-1:0] wb_dat_i,
	output logic      [OP_W-1:0] wb_dat_o,
	output logic                 wb_ack_o,
	output logic                 busy_o
);

	localparam int DATA_W = OP_W + 1;	// room for sign or zero extension

	logic                start, tmr_load, tmr_done, capture;
	logic [DATA_W-1:0]   op_a, op_b;
	logic [2*DATA_W-1:0] product;

	mul_regs #(
		.OP_W (OP_W)
	) i_mul_regs (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.busy_i    (busy_o),
		.capture_i (capture),
		.product_i (product),
		.start_o   (start),
		.op_a_o    (op_a),
		.op_b_o    (op_b)
	);

	mul_seq_fsm i_mul_seq_fsm (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.start_i    (start),
		.tmr_done_i (tmr_done),
		.tmr_load_o (tmr_load),
		.busy_o     (busy_o),
		.capture_o  (capture)
	);

	mul_latency_timer #(
		.LAT (MUL_LAT)
	) i_mul_latency_timer (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.tmr_load_i (tmr_load),
		.tmr_done_o (tmr_done)
	);

	alu_multiply #(
		.DATA_W (DATA_W)
	) i_alu_multiply (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.a_i      (op_a),
		.b_i      (op_b),
		.result_o (product)
	);

endmodule

`default_nettype wire

/* dv/mul_unit_tb.sv */
// testbench for mul_unit_top, wishbone inputs change 1 ns after each rising edge
// expected results come from a 64-bit model of the operand widening rule
// one access at a time, stb drops for one clock after every ack
// the run ends itself at a cycle limit sized from the table length

`timescale 1ns/100ps
`default_nettype none

module mul_unit_tb
	import mul_pkg::*;
();

	localparam int          N_EDGE = 100;	// 4 opcodes x 5 x 5 edge operands
	localparam int          N_RAND = 32;
	localparam int          N_ENT  = N_EDGE + N_RAND;
	localparam int unsigned LIMIT  = N_ENT * 30 + MUL_LAT * 10 + 200;

	logic        clk_i    = 1'b0;
	logic        rst_i    = 1'b1;
	logic        wb_cyc_i = 1'b0;
	logic        wb_stb_i = 1'b0;
	logic        wb_we_i  = 1'b0;
	logic [1:0]  wb_adr_i = 2'd0;
	logic [31:0] wb_dat_i = 32'd0;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	logic        busy_o;

	// stimulus table, expected column filled from the model
	string       t_name [N_ENT];
	mul_op_e     t_op   [N_ENT];
	logic [31:0] t_a    [N_ENT];
	logic [31:0] t_b    [N_ENT];
	logic [31:0] t_exp  [N_ENT];

	int unsigned cyc_cnt     = 0;
	int unsigned rise_cyc    = 0;	// cycle of the last busy rise
	int unsigned fall_cyc    = 0;	// and of the last fall
	int unsigned ack_cyc     = 0;
	logic        busy_q      = 1'b0;
	logic        busy_at_ack = 1'b0;
	int          errors      = 0;

	mul_unit_top #(
		.OP_W (32)
	) i_mul_unit_top (.*);

	always #5 clk_i = ~clk_i;

	always @(posedge clk_i)
		cyc_cnt <= cyc_cnt + 1;

	initial begin
		wait (cyc_cnt >= LIMIT);
		$display("timeout, the run did not finish within %0d cycles", LIMIT);
		$display("Checks failed");
		$finish;
	end

	// busy edges, sampled mid cycle where busy_o is settled
	always @(negedge clk_i) begin
		if (busy_o && !busy_q)
			rise_cyc = cyc_cnt;
		if (!busy_o && busy_q)
			fall_cyc = cyc_cnt;
		busy_q = busy_o;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// reference, 64-bit multiply of the widened operands mod 2^64
	function automatic logic [31:0] model_mul(input mul_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		logic [63:0] a64, b64, p;
		a64 = {32'd0, a};
		b64 = {32'd0, b};
		if ((op == MULH_SS || op == MULH_SU) && a[31])
			a64[63:32] = '1;	// a signed for SS and SU
		if (op == MULH_SS && b[31])
			b64[63:32] = '1;
		p = a64 * b64;
		return (op == MUL_LO) ? p[31:0] : p[63:32];
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// one classic cycle, called at a drive point, returns one clock after the ack
	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		do begin
			@(posedge clk_i);
			#1;
		end while (!wb_ack_o);
		rdat        = wb_dat_o;	// valid while ack is high
		ack_cyc     = cyc_cnt;
		busy_at_ack = busy_o;
		wb_cyc_i    = 1'b0;
		wb_stb_i    = 1'b0;
		wb_we_i     = 1'b0;
		@(posedge clk_i);
		#1;
	endtask

	initial begin
		logic [31:0] edge_v [5];
		logic [31:0] rd, seed;
		int unsigned ctrl_ack;
		int          n;
		edge_v = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
		n = 0;
		for (int k = 0; k < 4; k++)
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++) begin
					t_op[n]   = mul_op_e'(k[1:0]);
					t_a[n]    = edge_v[i];
					t_b[n]    = edge_v[j];
					t_name[n] = $sformatf("edge_%s_a%0d_b%0d", t_op[n].name(), i, j);
					n++;
				end
		seed = 32'h906b;
		for (int i = 0; i < N_RAND; i++) begin
			t_op[n]   = mul_op_e'(i[1:0]);	// walks through all opcodes
			seed      = xorshift32(seed);
			t_a[n]    = seed;
			seed      = xorshift32(seed);
			t_b[n]    = seed;
			t_name[n] = $sformatf("rand_%0d_%s", i, t_op[n].name());
			n++;
		end
		for (int i = 0; i < N_ENT; i++)
			t_exp[i] = model_mul(t_op[i], t_a[i], t_b[i]);

		repeat (5) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		repeat (2) begin
			@(posedge clk_i);
			#1;
			if (wb_ack_o || busy_o) begin
				errors++;
				$display("ack or busy went high after reset with no request");
			end
		end
		for (int r = 0; r < 4; r++) begin
			bus_cycle(1'b0, 2'(r), 32'd0, rd);
			check_val($sformatf("reset_reg%0d", r), 32'd0, rd);
		end

		// operand readback
		bus_cycle(1'b1, REG_OP_A, 32'h1357_9bdf, rd);
		bus_cycle(1'b1, REG_OP_B, 32'h8642_0eca, rd);
		bus_cycle(1'b0, REG_OP_A, 32'd0, rd);
		check_val("readback_op_a", 32'h1357_9bdf, rd);
		bus_cycle(1'b0, REG_OP_B, 32'd0, rd);
		check_val("readback_op_b", 32'h8642_0eca, rd);

		for (int i = 0; i < N_ENT; i++) begin
			bus_cycle(1'b1, REG_OP_A, t_a[i], rd);
			bus_cycle(1'b1, REG_OP_B, t_b[i], rd);
			bus_cycle(1'b1, REG_CTRL, {30'd0, t_op[i]}, rd);
			ctrl_ack = ack_cyc;
			bus_cycle(1'b0, REG_RESULT, 32'd0, rd);	// held off until busy falls
			check_val(t_name[i], t_exp[i], rd);
			check_val({t_name[i], "_busy_rise"}, ctrl_ack + 1, rise_cyc);
			check_val({t_name[i], "_busy_len"}, MUL_LAT + 2, fall_cyc - rise_cyc);
			if (busy_at_ack || ack_cyc <= fall_cyc) begin
				errors++;
				$display("%s: result read was acked before busy fell", t_name[i]);
			end
			bus_cycle(1'b0, REG_CTRL, 32'd0, rd);
			check_val({t_name[i], "_status"}, {29'd0, t_op[i], 1'b0}, rd);
		end

		// status read and operand write while an operation runs
		bus_cycle(1'b1, REG_OP_A, 32'd1234, rd);
		bus_cycle(1'b1, REG_OP_B, 32'd5678, rd);
		bus_cycle(1'b1, REG_CTRL, {30'd0, MUL_LO}, rd);
		ctrl_ack = ack_cyc;
		bus_cycle(1'b0, REG_CTRL, 32'd0, rd);
		if (!busy_at_ack || rd[0] !== 1'b1) begin
			errors++;
			$display("status read during an operation waited or did not show busy");
		end
		bus_cycle(1'b1, REG_OP_A, 32'd99, rd);
		if (fall_cyc <= ctrl_ack || ack_cyc <= fall_cyc) begin
			errors++;
			$display("operand write during an operation was acked before busy fell");
		end
		bus_cycle(1'b0, REG_RESULT, 32'd0, rd);
		check_val("stall_old_operands", model_mul(MUL_LO, 32'd1234, 32'd5678), rd);
		bus_cycle(1'b0, REG_OP_A, 32'd0, rd);
		check_val("stall_new_op_a", 32'd99, rd);

		$display("errors: %0d, table entries: %0d", errors, N_ENT);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
design/mul_pkg.sv
design/alu_multiply.sv
design/mul_regs.sv
design/mul_seq_fsm.sv
design/mul_latency_timer.sv
design/mul_unit_top.sv
dv/mul_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# run from the project root, exits non-zero on a build error or a failed check
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module mul_unit_tb -f files.f -o mul_unit_sim \
	&& ./obj_dir/mul_unit_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
